/* source/regRead_config.svh */
`ifndef REGREAD_CONFIG_SVH
`define REGREAD_CONFIG_SVH

// issue width, equal to the number of bypass lanes.
`define RR_LANES 4

// physical register file.
`define RR_PHYS_REGS 32
`define RR_PHYS_LOG 5
`define RR_DATA_WIDTH 32

// branch checkpoints, one mask bit each.
`define RR_CHECKPOINTS 4
`define RR_CHECKPOINTS_LOG 2

// opaque rest of the issue packet.
`define RR_PAYLOAD_WIDTH 24

`endif

/* source/regReadPkg.sv */
`default_nettype none

`include "regRead_config.svh"

package regReadPkg;

  typedef logic [`RR_PHYS_LOG-1:0] physTagT;

  typedef logic [`RR_DATA_WIDTH-1:0] regDataT;

  typedef logic [`RR_CHECKPOINTS-1:0] branchMaskT;

  // issue queue, lsq, active list, immediate, pc and cti fields ride in payload.
  typedef struct packed {
    branchMaskT branchMask;
    physTagT src1Tag;
    physTagT src2Tag;
    physTagT destTag;
    logic [`RR_PAYLOAD_WIDTH-1:0] payload;
  } issuePacketT;

  typedef struct packed {
    physTagT destTag;
    regDataT data;
  } bypassLaneT;

  // operands go in front of the issue packet.
  typedef struct packed {
    regDataT src2Data;
    regDataT src1Data;
    issuePacketT issuePkt;
  } readPacketT;

endpackage

`default_nettype wire

/* source/operandIf.sv */
`default_nettype none

`include "regRead_config.svh"

interface operandIf;

  regReadPkg::physTagT src1Tag [`RR_LANES];
  regReadPkg::physTagT src2Tag [`RR_LANES];

  // one bit per bypass lane.
  logic [`RR_LANES-1:0] src1Match [`RR_LANES];
  logic [`RR_LANES-1:0] src2Match [`RR_LANES];

  modport decoder (
    output src1Tag,
    output src2Tag,
    output src1Match,
    output src2Match
  );

  modport reader (
    input src1Tag,
    input src2Tag
  );

  modport selector (
    input src1Match,
    input src2Match
  );

endinterface

`default_nettype wire

/* source/sourceDecode.sv */
`default_nettype none

`include "regRead_config.svh"

module sourceDecode (
  input  regReadPkg::issuePacketT issuePkt_i [`RR_LANES],
  input  regReadPkg::bypassLaneT bypass_i [`RR_LANES],
  input  logic [`RR_LANES-1:0] bypassValid_i,
  operandIf.decoder operands
);

  // compare a source tag against every live bypass destination.
  function automatic logic [`RR_LANES-1:0] matchLanes(input regReadPkg::physTagT tag);
    logic [`RR_LANES-1:0] hits;
    hits = '0;
    for (int b = 0; b < `RR_LANES; b++)
    begin
      hits[b] = bypassValid_i[b] && (tag == bypass_i[b].destTag);
    end
    return hits;
  endfunction

  always_comb
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      operands.src1Tag[l] = issuePkt_i[l].src1Tag;
      operands.src2Tag[l] = issuePkt_i[l].src2Tag;
      operands.src1Match[l] = matchLanes(issuePkt_i[l].src1Tag);
      operands.src2Match[l] = matchLanes(issuePkt_i[l].src2Tag);
    end
  end

  // issue logic never sends two live lanes to one destination.
  for (genvar l = 0; l < `RR_LANES; l++)
  begin : gLaneCheck
    always_comb
    begin
      assert final ($onehot0(operands.src1Match[l]))
        else $error("lane %0d: source-1 bypass match not one-hot", l);
      assert final ($onehot0(operands.src2Match[l]))
        else $error("lane %0d: source-2 bypass match not one-hot", l);
    end
  end

endmodule

`default_nettype wire

/* source/physRegFile.sv */
`default_nettype none

`include "regRead_config.svh"

module physRegFile (
  input  logic clk,
  input  logic rstN_i,
  operandIf.reader operands,
  input  regReadPkg::bypassLaneT bypass_i [`RR_LANES],
  input  logic [`RR_LANES-1:0] bypassValid_i,
  input  logic recover_i,
  output regReadPkg::regDataT src1Data_o [`RR_LANES],
  output regReadPkg::regDataT src2Data_o [`RR_LANES]
);

  regReadPkg::regDataT regFile [`RR_PHYS_REGS];
  logic [`RR_LANES-1:0] writeEn;

  // recovery blocks every writeback.
  assign writeEn = bypassValid_i & {`RR_LANES{~recover_i}};

  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      for (int r = 0; r < `RR_PHYS_REGS; r++)
      begin
        regFile[r] <= '0;
      end
    end
    else
    begin
      for (int l = 0; l < `RR_LANES; l++)
      begin
        if (writeEn[l])
        begin
          regFile[bypass_i[l].destTag] <= bypass_i[l].data;
        end
      end
    end
  end

  // two read ports per issue lane.
  always_comb
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      src1Data_o[l] = regFile[operands.src1Tag[l]];
      src2Data_o[l] = regFile[operands.src2Tag[l]];
    end
  end

  for (genvar a = 0; a < `RR_LANES; a++)
  begin : gWriteCheck
    for (genvar b = a + 1; b < `RR_LANES; b++)
    begin : gPair
      assert property (@(posedge clk) disable iff (!rstN_i)
        !(writeEn[a] && writeEn[b] && (bypass_i[a].destTag == bypass_i[b].destTag)))
        else $error("write ports %0d and %0d hit one register", a, b);
    end
  end

endmodule

`default_nettype wire

/* source/operandSelect.sv */
`default_nettype none

`include "regRead_config.svh"

module operandSelect (
  operandIf.selector operands,
  input  regReadPkg::bypassLaneT bypass_i [`RR_LANES],
  input  regReadPkg::regDataT src1Data_i [`RR_LANES],
  input  regReadPkg::regDataT src2Data_i [`RR_LANES],
  input  regReadPkg::issuePacketT issuePkt_i [`RR_LANES],
  input  logic [`RR_LANES-1:0] issueValid_i,
  input  logic ctrlVerified_i,
  input  logic ctrlMispredict_i,
  input  logic [`RR_CHECKPOINTS_LOG-1:0] ctrlCheckpoint_i,
  output regReadPkg::readPacketT readPkt_o [`RR_LANES],
  output logic [`RR_LANES-1:0] readValid_o
);

  logic mispredictEvent;

  // forwarded data wins over the file.
  function automatic regReadPkg::regDataT pickOperand(
    input logic [`RR_LANES-1:0] match,
    input regReadPkg::regDataT fileData
  );
    regReadPkg::regDataT value;
    value = fileData;
    for (int b = 0; b < `RR_LANES; b++)
    begin
      if (match[b])
      begin
        value = bypass_i[b].data;
      end
    end
    return value;
  endfunction

  assign mispredictEvent = ctrlVerified_i & ctrlMispredict_i;

  always_comb
  begin
    for (int l = 0; l < `RR_LANES; l++)
    begin
      readPkt_o[l].src1Data = pickOperand(operands.src1Match[l], src1Data_i[l]);
      readPkt_o[l].src2Data = pickOperand(operands.src2Match[l], src2Data_i[l]);
      readPkt_o[l].issuePkt = issuePkt_i[l];
      // squash anything younger than the bad branch.
      readValid_o[l] = issueValid_i[l]
        & ~(mispredictEvent & issuePkt_i[l].branchMask[ctrlCheckpoint_i]);
    end
  end

endmodule

`default_nettype wire

/* source/regReadTop.sv */
`default_nettype none

`include "regRead_config.svh"

module regReadTop (
  input  logic clk,
  input  logic rstN_i,
  input  regReadPkg::issuePacketT issuePkt_i [`RR_LANES],
  input  logic [`RR_LANES-1:0] issueValid_i,
  input  regReadPkg::bypassLaneT bypass_i [`RR_LANES],
  input  logic [`RR_LANES-1:0] bypassValid_i,
  input  logic recover_i,
  input  logic ctrlVerified_i,
  input  logic ctrlMispredict_i,
  input  logic [`RR_CHECKPOINTS_LOG-1:0] ctrlCheckpoint_i,
  output regReadPkg::readPacketT readPkt_o [`RR_LANES],
  output logic [`RR_LANES-1:0] readValid_o
);

  regReadPkg::regDataT src1Data [`RR_LANES];
  regReadPkg::regDataT src2Data [`RR_LANES];

  // tags and bypass matches per issue lane.
  operandIf operands ();

  sourceDecode i_sourceDecode (
    .issuePkt_i    (issuePkt_i),
    .bypass_i      (bypass_i),
    .bypassValid_i (bypassValid_i),
    .operands      (operands.decoder)
  );

  // 8 read, 4 write ports.
  physRegFile i_physRegFile (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .operands      (operands.reader),
    .bypass_i      (bypass_i),
    .bypassValid_i (bypassValid_i),
    .recover_i     (recover_i),
    .src1Data_o    (src1Data),
    .src2Data_o    (src2Data)
  );

  operandSelect i_operandSelect (
    .operands         (operands.selector),
    .bypass_i         (bypass_i),
    .src1Data_i       (src1Data),
    .src2Data_i       (src2Data),
    .issuePkt_i       (issuePkt_i),
    .issueValid_i     (issueValid_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCheckpoint_i (ctrlCheckpoint_i),
    .readPkt_o        (readPkt_o),
    .readValid_o      (readValid_o)
  );

endmodule

`default_nettype wire

/* verification/regReadTb.sv */
`default_nettype none

`include "regRead_config.svh"

module regReadTb;

  localparam int halfPeriod = 20;
  localparam int resetCycles = 4;
  localparam int randomCycles = 400;
  // driven cycles of all tests together.
  localparam int testCycles = 4 + 4 + 4 + 2 + 16 + randomCycles;
  localparam int timeoutCycles = 2 * testCycles + resetCycles;

  logic clk;
  logic rstN;
  regReadPkg::issuePacketT issuePkt [`RR_LANES];
  logic [`RR_LANES-1:0] issueValid;
  regReadPkg::bypassLaneT bypass [`RR_LANES];
  logic [`RR_LANES-1:0] bypassValid;
  logic recover;
  logic ctrlVerified;
  logic ctrlMispredict;
  logic [`RR_CHECKPOINTS_LOG-1:0] ctrlCheckpoint;
  regReadPkg::readPacketT readPkt [`RR_LANES];
  logic [`RR_LANES-1:0] readValid;

  regReadPkg::regDataT shadow [`RR_PHYS_REGS];
  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int checkMark = 0;
  int errorMark = 0;

  regReadTop i_regReadTop (
    .clk              (clk),
    .rstN_i           (rstN),
    .issuePkt_i       (issuePkt),
    .issueValid_i     (issueValid),
    .bypass_i         (bypass),
    .bypassValid_i    (bypassValid),
    .recover_i        (recover),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCheckpoint_i (ctrlCheckpoint),
    .readPkt_o        (readPkt),
    .readValid_o      (readValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // shadow copy of the register file.
  always @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int r = 0; r < `RR_PHYS_REGS; r++)
      begin
        shadow[r] = '0;
      end
    end
    else if (!recover)
    begin
      for (int b = 0; b < `RR_LANES; b++)
      begin
        if (bypassValid[b])
        begin
          shadow[bypass[b].destTag] = bypass[b].data;
        end
      end
    end
  end

  // live bypass data first, else the stored value.
  function automatic regReadPkg::regDataT expectOperand(input regReadPkg::physTagT tag);
    regReadPkg::regDataT value;
    value = shadow[tag];
    for (int b = 0; b < `RR_LANES; b++)
    begin
      if (bypassValid[b] && (bypass[b].destTag == tag))
      begin
        value = bypass[b].data;
      end
    end
    return value;
  endfunction

  function automatic logic expectValid(input int lane);
    logic squash;
    squash = ctrlVerified && ctrlMispredict && issuePkt[lane].branchMask[ctrlCheckpoint];
    return issueValid[lane] && !squash;
  endfunction

  // outputs settle well before the next rising edge.
  initial
  begin
    regReadPkg::readPacketT expected;
    forever
    begin
      @(negedge clk);
      #(halfPeriod - 5);
      if (rstN)
      begin
        for (int l = 0; l < `RR_LANES; l++)
        begin
          expected.src2Data = expectOperand(issuePkt[l].src2Tag);
          expected.src1Data = expectOperand(issuePkt[l].src1Tag);
          expected.issuePkt = issuePkt[l];
          checkCount += 2;
          assert (readPkt[l] === expected)
          else
          begin
            errorCount++;
            $display("[FAIL] %0t: lane %0d packet %h, expected %h",
              $time, l, readPkt[l], expected);
          end
          assert (readValid[l] === expectValid(l))
          else
          begin
            errorCount++;
            $display("[FAIL] %0t: lane %0d valid %b, expected %b",
              $time, l, readValid[l], expectValid(l));
          end
        end
      end
    end
  end

  initial
  begin
    while (cycleCount < timeoutCycles)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic clearInputs();
    for (int l = 0; l < `RR_LANES; l++)
    begin
      issuePkt[l] = '0;
      bypass[l] = '0;
    end
    issueValid = '0;
    bypassValid = '0;
    recover = 1'b0;
    ctrlVerified = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCheckpoint = '0;
  endtask

  task automatic nextCycle();
    @(negedge clk);
    clearInputs();
  endtask

  task automatic finishTest(input string name);
    int errs;
    @(posedge clk);
    errs = errorCount - errorMark;
    testsRun++;
    if (errs != 0)
    begin
      testsFailed++;
    end
    $display("test %0d %s: %0d checks, %0d errors", testsRun, name,
      checkCount - checkMark, errs);
    checkMark = checkCount;
    errorMark = errorCount;
  endtask

  function automatic regReadPkg::issuePacketT makePacket(input int src1, input int src2);
    regReadPkg::issuePacketT pkt;
    pkt.branchMask = regReadPkg::branchMaskT'($urandom);
    pkt.src1Tag = regReadPkg::physTagT'(src1);
    pkt.src2Tag = regReadPkg::physTagT'(src2);
    pkt.destTag = regReadPkg::physTagT'($urandom);
    pkt.payload = `RR_PAYLOAD_WIDTH'($urandom);
    return pkt;
  endfunction

  // half the time a tag that a live lane is writing.
  function automatic int pickTag();
    if ($urandom % 2)
    begin
      return bypass[$urandom % `RR_LANES].destTag;
    end
    return $urandom % `RR_PHYS_REGS;
  endfunction

  task automatic writeLanes(input int firstTag);
    for (int b = 0; b < `RR_LANES; b++)
    begin
      bypass[b].destTag = regReadPkg::physTagT'(firstTag + b);
      bypass[b].data = $urandom;
    end
    bypassValid = '1;
  endtask

  initial
  begin
    int base;
    void'($urandom(22406));
    clearInputs();
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // every tag reads zero after reset.
    for (int c = 0; c < 4; c++)
    begin
      nextCycle();
      for (int l = 0; l < `RR_LANES; l++)
      begin
        issuePkt[l] = makePacket(8 * c + 2 * l, 8 * c + 2 * l + 1);
      end
      issueValid = '1;
    end
    finishTest("reset readback");

    for (int c = 0; c < 2; c++)
    begin
      nextCycle();
      writeLanes(4 * c);
    end
    nextCycle();
    for (int l = 0; l < `RR_LANES; l++)
    begin
      issuePkt[l] = makePacket(l, l + 4);
    end
    issueValid = '1;
    nextCycle();
    for (int l = 0; l < `RR_LANES; l++)
    begin
      issuePkt[l] = makePacket(7 - l, 3 - l);
    end
    issueValid = '1;
    finishTest("file writeback");

    // fresh tags, so the file still holds zero.
    for (int c = 0; c < 4; c++)
    begin
      nextCycle();
      writeLanes(16 + 4 * c);
      for (int l = 0; l < `RR_LANES; l++)
      begin
        issuePkt[l] = makePacket(16 + 4 * c + l, 16 + 4 * c + (l + 1) % `RR_LANES);
      end
      issueValid = '1;
    end
    finishTest("same-cycle forwarding");

    nextCycle();
    recover = 1'b1;
    writeLanes(0);
    for (int l = 0; l < `RR_LANES; l++)
    begin
      issuePkt[l] = makePacket(l, (l + 1) % `RR_LANES);
    end
    issueValid = '1;
    nextCycle();
    for (int l = 0; l < `RR_LANES; l++)
    begin
      issuePkt[l] = makePacket(l, 3 - l);
    end
    issueValid = '1;
    finishTest("recover blocks writes");

    // every checkpoint against each verified/mispredict pair.
    for (int c = 0; c < 16; c++)
    begin
      nextCycle();
      ctrlCheckpoint = c / 4;
      ctrlVerified = c[0];
      ctrlMispredict = c[1];
      for (int l = 0; l < `RR_LANES; l++)
      begin
        issuePkt[l] = makePacket($urandom, $urandom);
        issuePkt[l].branchMask = regReadPkg::branchMaskT'(4'b0011 << l);
      end
      issueValid = '1;
    end
    finishTest("mispredict squash");

    for (int c = 0; c < randomCycles; c++)
    begin
      nextCycle();
      base = $urandom % `RR_PHYS_REGS;
      // one group of eight tags per lane keeps destinations distinct.
      for (int b = 0; b < `RR_LANES; b++)
      begin
        bypass[b].destTag = regReadPkg::physTagT'(base + 8 * b + $urandom % 8);
        bypass[b].data = $urandom;
      end
      bypassValid = $urandom;
      recover = ($urandom % 8) == 0;
      ctrlVerified = ($urandom % 4) == 0;
      ctrlMispredict = $urandom % 2;
      ctrlCheckpoint = $urandom;
      for (int l = 0; l < `RR_LANES; l++)
      begin
        issuePkt[l] = makePacket(pickTag(), pickTag());
      end
      issueValid = $urandom;
    end
    finishTest("random mix");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
      testsRun, testsFailed, checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/regReadPkg.sv
source/operandIf.sv
source/sourceDecode.sv
source/physRegFile.sv
source/operandSelect.sv
source/regReadTop.sv
verification/regReadTb.sv

/* Bender.yml */
package:
  name: reg_read

sources:
  - include_dirs:
      - source
    files:
      - source/regReadPkg.sv
      - source/operandIf.sv
      - source/sourceDecode.sv
      - source/physRegFile.sv
      - source/operandSelect.sv
      - source/regReadTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/regReadTb.sv
